//--- arcade_cfg_pkg.sv
/*
 * Board configuration definitions
 * Game codes, download-bus indexes, DIP bank type and
 * the default CPU clock-divider ratios
 */

package arcade_cfg_pkg;

	// ====================
	// Game identifiers
	// ====================

	// Loaded once from the download bus before the game starts
	typedef enum logic [7:0] {
		SPACE_PANIC  = 8'd1,
		MAGICAL_SPOT = 8'd2,
		COSMIC_ALIEN = 8'd3,
		DEVIL_ZONE   = 8'd4,
		NO_MANS_LAND = 8'd5,
		GAME_NONE    = 8'd255  // nothing loaded yet
	} game_id_t;

	// ====================
	// Download indexes
	// ====================

	// Index carrying the single game-code byte
	localparam logic [7:0] GAME_ID_INDEX = 8'd1;
	// Index carrying the DIP-switch bytes, one per address
	localparam logic [7:0] DIP_INDEX     = 8'd254;

	// ====================
	// DIP switches
	// ====================

	// Number of switch bytes kept by the board
	localparam int DIP_BANKS = 8;

	// Bank 0 sits in the low byte
	typedef logic [DIP_BANKS-1:0][7:0] dip_bank_t;

	// ====================
	// Clock dividers
	// ====================

	// clk_sys divide ratio for the 2.7 MHz CPU games
	localparam int FAST_DIV = 4;
	// clk_sys divide ratio for the 1.8 MHz CPU games
	localparam int SLOW_DIV = 6;

endpackage

//--- arcade_input_pkg.sv
/*
 * Player-input definitions
 * Download bus, PS/2 key, joystick, player-control and
 * input-port structs, plus the PS/2 scan-code table
 */

package arcade_input_pkg;

	// Single-cycle write strobe with index, address and byte
	typedef struct packed {
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_bus_t;

	// Toggle flips on every new key event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

	// Joystick word, bit 0 is right
	typedef struct packed {
		logic [6:0] unused;
		logic       coin;
		logic       start_2;
		logic       start_1;
		logic       fire_b;
		logic       fire_a;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// One player's controls, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic start;
		logic coin;
	} player_ctrl_t;

	// Keyboard latches for both players
	typedef struct packed {
		player_ctrl_t p1;
		player_ctrl_t p2;
	} key_state_t;

	// The four bytes the CPU reads, all active low
	typedef struct packed {
		logic [7:0] in0;
		logic [7:0] in1;
		logic [7:0] in2;
		logic [7:0] dip;
	} input_ports_t;

	// ====================
	// Scan codes
	// ====================

	// Cursor block and function keys, player 1
	localparam logic [8:0] KEY_UP       = 9'h075;
	localparam logic [8:0] KEY_DOWN     = 9'h072;
	localparam logic [8:0] KEY_LEFT     = 9'h06B;
	localparam logic [8:0] KEY_RIGHT    = 9'h074;
	localparam logic [8:0] KEY_COIN     = 9'h076;  // ESC
	localparam logic [8:0] KEY_START1   = 9'h005;  // F1
	localparam logic [8:0] KEY_START2   = 9'h006;  // F2
	localparam logic [8:0] KEY_FIRE_A   = 9'h014;  // left ctrl
	localparam logic [8:0] KEY_FIRE_B   = 9'h011;  // left alt

	// MAME / JPAC style layout
	localparam logic [8:0] KEY_M_START1 = 9'h016;  // 1
	localparam logic [8:0] KEY_M_START2 = 9'h01E;  // 2
	localparam logic [8:0] KEY_M_COIN1  = 9'h02E;  // 5
	localparam logic [8:0] KEY_M_COIN2  = 9'h036;  // 6
	localparam logic [8:0] KEY_M_UP2    = 9'h02D;  // R
	localparam logic [8:0] KEY_M_DOWN2  = 9'h02B;  // F
	localparam logic [8:0] KEY_M_LEFT2  = 9'h023;  // D
	localparam logic [8:0] KEY_M_RIGHT2 = 9'h034;  // G
	localparam logic [8:0] KEY_M_FIRE2A = 9'h01C;  // A
	localparam logic [8:0] KEY_M_FIRE2B = 9'h01B;  // S

endpackage

//--- ps2_key_decoder.sv
/*
 * PS/2 key event decoder
 * Edge-detects the event toggle and keeps one pressed latch
 * per key function for both players
 */

`timescale 1ns/10ps

module ps2_key_decoder
	import arcade_input_pkg::*;
(
	input  logic       clk_sys,
	input  logic       arst_n,
	input  ps2_key_t   ps2_key,
	output key_state_t keys
);

	// Toggle as seen on the previous edge
	logic toggle_q;
	logic new_event;

	// Any flip of the toggle marks a fresh make or break code
	assign new_event = (ps2_key.toggle != toggle_q);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q <= 1'b0;
			keys     <= '0;
		end else begin
			toggle_q <= ps2_key.toggle;

			if (new_event) begin
				// Latch follows make (1) or break (0)
				case (ps2_key.code)
					// ====================
					// Player 1, cursor keys
					// ====================
					KEY_UP:       keys.p1.up     <= ps2_key.pressed;
					KEY_DOWN:     keys.p1.down   <= ps2_key.pressed;
					KEY_LEFT:     keys.p1.left   <= ps2_key.pressed;
					KEY_RIGHT:    keys.p1.right  <= ps2_key.pressed;
					KEY_FIRE_A:   keys.p1.fire_a <= ps2_key.pressed;
					KEY_FIRE_B:   keys.p1.fire_b <= ps2_key.pressed;
					KEY_COIN:     keys.p1.coin   <= ps2_key.pressed;
					KEY_START1:   keys.p1.start  <= ps2_key.pressed;
					// Start 2 belongs to the second player
					KEY_START2:   keys.p2.start  <= ps2_key.pressed;

					// ====================
					// MAME style alternates
					// ====================
					KEY_M_START1: keys.p1.start  <= ps2_key.pressed;
					KEY_M_START2: keys.p2.start  <= ps2_key.pressed;
					KEY_M_COIN1:  keys.p1.coin   <= ps2_key.pressed;
					KEY_M_COIN2:  keys.p2.coin   <= ps2_key.pressed;
					KEY_M_UP2:    keys.p2.up     <= ps2_key.pressed;
					KEY_M_DOWN2:  keys.p2.down   <= ps2_key.pressed;
					KEY_M_LEFT2:  keys.p2.left   <= ps2_key.pressed;
					KEY_M_RIGHT2: keys.p2.right  <= ps2_key.pressed;
					KEY_M_FIRE2A: keys.p2.fire_a <= ps2_key.pressed;
					KEY_M_FIRE2B: keys.p2.fire_b <= ps2_key.pressed;

					// Unlisted codes leave every latch alone
					default: begin
					end
				endcase
			end
		end
	end

endmodule

//--- config_loader.sv
/*
 * Configuration capture from the download bus
 * Game code register and DIP-switch bank
 */

`timescale 1ns/10ps

module config_loader
	import arcade_cfg_pkg::*;
	import arcade_input_pkg::*;
#(
	parameter int DIP_BANKS = arcade_cfg_pkg::DIP_BANKS
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  dl_bus_t    dl,
	output game_id_t   game,
	output dip_bank_t  dips,
	output logic [7:0] dip2,
	output logic       flip
);

	// Address bits needed to pick a byte of the bank type
	localparam int          BANK_AW    = $clog2($bits(dip_bank_t) / 8);
	// Addresses at or past this limit are dropped
	localparam logic [24:0] BANK_LIMIT = 25'(DIP_BANKS);

	logic game_wr;
	logic dip_wr;

	// Index decode of the write strobe
	assign game_wr = dl.wr && (dl.index == GAME_ID_INDEX);
	assign dip_wr  = dl.wr && (dl.index == DIP_INDEX) && (dl.addr < BANK_LIMIT);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game <= GAME_NONE;
			dips <= '0;
		end else begin
			if (game_wr) begin
				game <= game_id_t'(dl.data);
			end
			// One byte per address, low bank first
			if (dip_wr) begin
				dips[dl.addr[BANK_AW-1:0]] <= dl.data;
			end
		end
	end

	// Bank 1 goes to the board as the second switch byte
	assign dip2 = dips[1];
	// Screen flip select lives in bank 2 bit 0
	assign flip = dips[2][0];

endmodule

//--- cpu_clock_enables.sv
/*
 * Clock enables derived from clk_sys
 * Pixel enable plus a CPU enable at the rate the game needs
 */

`timescale 1ns/10ps

module cpu_clock_enables
	import arcade_cfg_pkg::*;
#(
	parameter int FAST_DIV = arcade_cfg_pkg::FAST_DIV,
	parameter int SLOW_DIV = arcade_cfg_pkg::SLOW_DIV
) (
	input  logic     clk_sys,
	input  logic     arst_n,
	input  game_id_t game,
	output logic     pix_ena,
	output logic     cpu_ena
);

	localparam int FAST_W = $clog2(FAST_DIV);
	localparam int SLOW_W = $clog2(SLOW_DIV);

	// Fast divider doubles as the pixel divider, as on the PCB
	logic [FAST_W-1:0] fast_cnt;
	logic [SLOW_W-1:0] slow_cnt;
	// One-cycle CPU pulses at each rate
	logic              fast_pulse;
	logic              slow_pulse;
	logic              fast_game;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			fast_cnt   <= '0;
			slow_cnt   <= '0;
			fast_pulse <= 1'b0;
			slow_pulse <= 1'b0;
		end else begin
			fast_cnt   <= (fast_cnt == FAST_W'(FAST_DIV - 1)) ? '0 : fast_cnt + 1'b1;
			slow_cnt   <= (slow_cnt == SLOW_W'(SLOW_DIV - 1)) ? '0 : slow_cnt + 1'b1;
			fast_pulse <= (fast_cnt == FAST_W'(FAST_DIV - 1));
			slow_pulse <= (slow_cnt == SLOW_W'(SLOW_DIV - 1));
		end
	end

	// Half of clk_sys
	assign pix_ena = fast_cnt[0];

	// Magical Spot and Devil Zone run the faster Z80
	assign fast_game = (game == MAGICAL_SPOT) || (game == DEVIL_ZONE);
	assign cpu_ena   = fast_game ? fast_pulse : slow_pulse;

endmodule

//--- input_port_mapper.sv
/*
 * Per-game input port formatting
 * Merges joystick and keyboard controls and registers
 * the four active-low bytes read by the CPU
 */

`timescale 1ns/10ps

module input_port_mapper
	import arcade_cfg_pkg::*;
	import arcade_input_pkg::*;
(
	input  logic         clk_sys,
	input  logic         arst_n,
	input  key_state_t   keys,
	input  joy_t         joy1,
	input  joy_t         joy2,
	input  game_id_t     game,
	input  dip_bank_t    dips,
	input  logic         vblank,
	input  logic [8:0]   vcount,
	output input_ports_t ports
);

	// Player start on each pad is its own start_1 bit
	function automatic player_ctrl_t joy_to_ctrl(input joy_t j);
		player_ctrl_t c;
		c.up     = j.up;
		c.down   = j.down;
		c.left   = j.left;
		c.right  = j.right;
		c.fire_a = j.fire_a;
		c.fire_b = j.fire_b;
		c.start  = j.start_1;
		c.coin   = j.coin;
		return c;
	endfunction

	// Space Panic player byte
	function automatic logic [7:0] panic_byte(input player_ctrl_t c);
		return {~c.fire_b, 2'b11, ~c.up, ~c.down, ~c.left, ~c.right, ~c.fire_a};
	endfunction

	// No Man's Land diagonals have their own codes, fire overrides all
	function automatic logic [7:0] nml_byte(input player_ctrl_t c);
		if (c.fire_a)                return 8'hFF;
		else if (c.up && c.left)     return 8'hFE;
		else if (c.down && c.left)   return 8'hFB;
		else if (c.down && c.right)  return 8'hEF;
		else if (c.up && c.right)    return 8'hBF;
		else return {~c.up, 1'b1, ~c.right, 1'b1, ~c.down, 1'b1, ~c.left, 1'b1};
	endfunction

	// Cosmic Alien player byte
	function automatic logic [7:0] alien_byte(input player_ctrl_t c);
		return {5'h1F, ~c.left, ~c.right, ~c.fire_a};
	endfunction

	player_ctrl_t p1;
	player_ctrl_t p2;
	logic         start1;
	logic         start2;
	logic         coin;
	logic [7:0]   mag_in2;
	logic [7:0]   mag_dip;
	input_ports_t ports_d;

	// ====================
	// Control merge
	// ====================

	assign p1     = keys.p1 | joy_to_ctrl(joy1);
	assign p2     = keys.p2 | joy_to_ctrl(joy2);
	// Pad 1 also carries a second start button
	assign start1 = p1.start;
	assign start2 = p2.start | joy1.start_2;
	// Either coin key credits the single slot
	assign coin   = p1.coin | p2.coin;

	// Shared by Magical Spot, Devil Zone and No Man's Land
	assign mag_in2 = {~p1.fire_a, ~p2.fire_a, 5'h1F, ~vblank};
	assign mag_dip = {~start1, ~start2, dips[0][5:0]};

	// ====================
	// Per-game layout
	// ====================

	always_comb begin
		case (game)
			SPACE_PANIC: begin
				ports_d.in0 = panic_byte(p1);
				ports_d.in1 = panic_byte(p2);
				ports_d.in2 = {1'b1, ~coin, 4'hF, ~start2, ~start1};
				ports_d.dip = dips[0];
			end
			MAGICAL_SPOT, DEVIL_ZONE: begin
				// Top two bits are bonus switches from bank 1
				ports_d.in0 = {dips[1][7:6], ~p1.right, 3'b111, ~p1.left, 1'b1};
				ports_d.in1 = {2'b11, ~p2.right, 3'b111, ~p2.left, 1'b1};
				ports_d.in2 = mag_in2;
				ports_d.dip = mag_dip;
			end
			NO_MANS_LAND: begin
				ports_d.in0 = nml_byte(p1);
				ports_d.in1 = nml_byte(p2);
				ports_d.in2 = mag_in2;
				ports_d.dip = mag_dip;
			end
			default: begin
				// Cosmic Alien reads the beam line on in2
				ports_d.in0 = alien_byte(p1);
				ports_d.in1 = alien_byte(p2);
				ports_d.in2 = {2'b00, vcount[7:2]};
				ports_d.dip = mag_dip;
			end
		endcase
	end

	// Idle inputs read all ones
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ports <= '1;
		end else begin
			ports <= ports_d;
		end
	end

endmodule

//--- cosmic_inputs_top.sv
/*
 * Input and timing front end of the Cosmic series board
 * Key decoder, configuration loader, clock enables and port mapper
 */

`timescale 1ns/10ps

module cosmic_inputs_top
	import arcade_cfg_pkg::*;
	import arcade_input_pkg::*;
#(
	parameter int DIP_BANKS = arcade_cfg_pkg::DIP_BANKS,
	parameter int FAST_DIV  = arcade_cfg_pkg::FAST_DIV,
	parameter int SLOW_DIV  = arcade_cfg_pkg::SLOW_DIV
) (
	input  logic         clk_sys,
	input  logic         arst_n,
	input  dl_bus_t      dl,
	input  ps2_key_t     ps2_key,
	input  joy_t         joy1,
	input  joy_t         joy2,
	input  logic         vblank,
	input  logic [8:0]   vcount,
	output input_ports_t ports,
	output logic [7:0]   dip2,
	output logic         flip,
	output logic         cpu_ena,
	output logic         pix_ena
);

	key_state_t keys;
	game_id_t   game;
	dip_bank_t  dips;

	// Keyboard events into button latches
	ps2_key_decoder u_keys (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.ps2_key (ps2_key),
		.keys    (keys)
	);

	// Game code and switch bytes from the loader
	config_loader #(
		.DIP_BANKS (DIP_BANKS)
	) u_cfg (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.dl      (dl),
		.game    (game),
		.dips    (dips),
		.dip2    (dip2),
		.flip    (flip)
	);

	// CPU rate follows the loaded game
	cpu_clock_enables #(
		.FAST_DIV (FAST_DIV),
		.SLOW_DIV (SLOW_DIV)
	) u_clk (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.game    (game),
		.pix_ena (pix_ena),
		.cpu_ena (cpu_ena)
	);

	// ====================
	// CPU input bytes
	// ====================

	input_port_mapper u_map (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.keys    (keys),
		.joy1    (joy1),
		.joy2    (joy2),
		.game    (game),
		.dips    (dips),
		.vblank  (vblank),
		.vcount  (vcount),
		.ports   (ports)
	);

endmodule

//--- tb_cosmic_vectors.svh
/*
 * Testbench vectors
 * Row type of the stimulus table, key-event modes and the
 * reference model for rows that carry no key event
 */

`ifndef TB_COSMIC_VECTORS_SVH
`define TB_COSMIC_VECTORS_SVH

// Key event carried by a row
localparam logic [1:0] EV_NONE   = 2'd0;
localparam logic [1:0] EV_NEW    = 2'd1;  // toggle flips
localparam logic [1:0] EV_REPEAT = 2'd2;  // toggle held, must be ignored

// One table row, expected ports in the last field
typedef struct packed {
	game_id_t     game;
	joy_t         joy1;
	joy_t         joy2;
	logic         vblank;
	logic [8:0]   vcount;
	logic [1:0]   ev;
	logic         pressed;
	logic [8:0]   code;
	input_ports_t exp_ports;
} vector_t;

// ====================
// Reference model
// ====================

// Player byte for one pad, active low, idle bits high
function automatic logic [7:0] player_model(input game_id_t game, input joy_t j,
		input logic [1:0] top);
	logic [7:0] b;
	b = 8'hFF;
	case (game)
		SPACE_PANIC: begin
			b[7] = ~j.fire_b;
			b[4] = ~j.up;
			b[3] = ~j.down;
			b[2] = ~j.left;
			b[1] = ~j.right;
			b[0] = ~j.fire_a;
		end
		MAGICAL_SPOT, DEVIL_ZONE: begin
			// Top bits come from bank 1 on player 1 only
			b[7:6] = top;
			b[5]   = ~j.right;
			b[1]   = ~j.left;
		end
		NO_MANS_LAND: begin
			// Fire held reads all ones
			if (!j.fire_a) begin
				if (j.up && j.left)
					b = 8'hFE;
				else if (j.down && j.left)
					b = 8'hFB;
				else if (j.down && j.right)
					b = 8'hEF;
				else if (j.up && j.right)
					b = 8'hBF;
				else begin
					b[7] = ~j.up;
					b[5] = ~j.right;
					b[3] = ~j.down;
					b[1] = ~j.left;
				end
			end
		end
		default: begin
			b[2] = ~j.left;
			b[1] = ~j.right;
			b[0] = ~j.fire_a;
		end
	endcase
	return b;
endfunction

// Four port bytes with the keyboard latches clear
function automatic input_ports_t expected_ports(input game_id_t game, input joy_t j1,
		input joy_t j2, input logic vblank, input logic [8:0] vcount, input dip_bank_t dips);
	input_ports_t p;
	logic         start1;
	logic         start2;
	start1 = j1.start_1;
	// Pad 1 start 2 counts as a second-player start
	start2 = j2.start_1 | j1.start_2;
	p.in0  = player_model(game, j1, dips[1][7:6]);
	p.in1  = player_model(game, j2, 2'b11);
	// Layout shared by games 2, 4 and 5
	p.in2  = {~j1.fire_a, ~j2.fire_a, 5'h1F, ~vblank};
	p.dip  = {~start1, ~start2, dips[0][5:0]};
	if (game == SPACE_PANIC) begin
		p.in2 = {1'b1, ~(j1.coin | j2.coin), 4'hF, ~start2, ~start1};
		p.dip = dips[0];
	end else if (!(game inside {MAGICAL_SPOT, DEVIL_ZONE, NO_MANS_LAND})) begin
		// Beam line for Cosmic Alien and unknown codes
		p.in2 = {2'b00, vcount[7:2]};
	end
	return p;
endfunction

`endif

//--- tb_cosmic_inputs.sv
/*
 * Testbench for the input and timing front end
 * Clock and reset, stimulus table loop, DIP checks,
 * CPU-rate and per-game switch routing checks, and a watchdog
 */

`timescale 1ns/10ps

module tb_cosmic_inputs
	import arcade_cfg_pkg::*;
	import arcade_input_pkg::*;
();

	`include "tb_cosmic_vectors.svh"

	localparam int ROWS_PER_GAME = 6;
	localparam int KEY_ROWS      = 6;
	localparam int NUM_ROWS      = 5 * ROWS_PER_GAME + KEY_ROWS;
	// Pulse counting window in clk_sys cycles
	localparam int WINDOW        = 24;
	localparam int LIMIT_CYCLES  = NUM_ROWS * 5 + 400;

	logic         clk_sys;
	logic         arst_n;
	dl_bus_t      dl;
	ps2_key_t     ps2_key;
	joy_t         joy1;
	joy_t         joy2;
	logic         vblank;
	logic [8:0]   vcount;
	input_ports_t ports;
	logic [7:0]   dip2;
	logic         flip;
	logic         cpu_ena;
	logic         pix_ena;

	vector_t      table_rows[$];
	// Expected contents of the DIP bank
	dip_bank_t    dip_model;
	logic         key_toggle;

	cosmic_inputs_top DUT (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.dl      (dl),
		.ps2_key (ps2_key),
		.joy1    (joy1),
		.joy2    (joy2),
		.vblank  (vblank),
		.vcount  (vcount),
		.ports   (ports),
		.dip2    (dip2),
		.flip    (flip),
		.cpu_ena (cpu_ena),
		.pix_ena (pix_ena)
	);

	// 100 ns clock
	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ====================
	// Helpers
	// ====================

	task automatic stop_on_failure();
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		assert (got == exp) else begin
			$display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_ports(input input_ports_t exp);
		check_value("ports.in0", ports.in0, exp.in0);
		check_value("ports.in1", ports.in1, exp.in1);
		check_value("ports.in2", ports.in2, exp.in2);
		check_value("ports.dip", ports.dip, exp.dip);
	endtask

	// One download-bus write strobe
	task automatic write_config(input logic [7:0] index, input logic [24:0] addr,
			input logic [7:0] data);
		dl_bus_t w;
		w.wr    = 1'b1;
		w.index = index;
		w.addr  = addr;
		w.data  = data;
		@(posedge clk_sys);
		dl <= w;
		@(posedge clk_sys);
		dl <= '0;
	endtask

	// Game write, pads and key event go out on one edge and are checked 3 cycles later
	task automatic apply_row(input vector_t v);
		ps2_key_t k;
		dl_bus_t  w;
		k       = ps2_key;
		w.wr    = 1'b1;
		w.index = GAME_ID_INDEX;
		w.addr  = '0;
		w.data  = v.game;
		if (v.ev != EV_NONE) begin
			if (v.ev == EV_NEW)
				key_toggle = ~key_toggle;
			k.toggle  = key_toggle;
			k.pressed = v.pressed;
			k.code    = v.code;
		end
		@(posedge clk_sys);
		dl      <= w;
		joy1    <= v.joy1;
		joy2    <= v.joy2;
		vblank  <= v.vblank;
		vcount  <= v.vcount;
		ps2_key <= k;
		@(posedge clk_sys);
		dl <= '0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_ports(v.exp_ports);
	endtask

	// Enables sampled mid-cycle over the window
	task automatic count_pulses(output int cpu_n, output int pix_n);
		cpu_n = 0;
		pix_n = 0;
		repeat (WINDOW) begin
			@(negedge clk_sys);
			cpu_n += int'(cpu_ena);
			pix_n += int'(pix_ena);
		end
	endtask

	// Key rows run under Space Panic with bank 0 still zero
	function automatic void add_key_row(input logic [1:0] ev, input logic pressed,
			input logic [8:0] code, input joy_t j2, input logic [31:0] exp);
		vector_t v;
		v           = '0;
		v.game      = SPACE_PANIC;
		v.joy2      = j2;
		v.ev        = ev;
		v.pressed   = pressed;
		v.code      = code;
		v.exp_ports = exp;
		table_rows.push_back(v);
	endfunction

	task automatic build_table();
		vector_t     v;
		logic [31:0] r;
		for (int g = 1; g <= 5; g++) begin
			for (int n = 0; n < ROWS_PER_GAME; n++) begin
				v        = '0;
				v.game   = game_id_t'(8'(g));
				r        = $urandom;
				v.joy1   = r[15:0];
				v.joy2   = r[31:16];
				r        = $urandom;
				v.vblank = r[9];
				v.vcount = r[8:0];
				v.ev     = EV_NONE;
				v.exp_ports = expected_ports(v.game, v.joy1, v.joy2, v.vblank,
					v.vcount, dip_model);
				table_rows.push_back(v);
			end
		end
		add_key_row(EV_NEW, 1'b1, KEY_LEFT, 16'h0000, 32'hFBFF_FF00);
		add_key_row(EV_NEW, 1'b0, KEY_LEFT, 16'h0000, 32'hFFFF_FF00);
		add_key_row(EV_NEW, 1'b1, KEY_M_LEFT2, 16'h0000, 32'hFFFB_FF00);
		// Pad 2 left still held after the key goes up
		add_key_row(EV_NEW, 1'b0, KEY_M_LEFT2, 16'h0002, 32'hFFFB_FF00);
		add_key_row(EV_NEW, 1'b1, 9'h0AA, 16'h0000, 32'hFFFF_FF00);
		add_key_row(EV_REPEAT, 1'b1, KEY_LEFT, 16'h0000, 32'hFFFF_FF00);
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		int          cpu_n;
		int          pix_n;
		logic [31:0] r;
		logic [7:0]  data;
		logic        fast;
		void'($urandom(4));
		arst_n     = 1'b0;
		dl         = '0;
		ps2_key    = '0;
		joy1       = '0;
		joy2       = '0;
		vblank     = 1'b0;
		vcount     = 9'h1B5;
		key_toggle = 1'b0;
		dip_model  = '0;
		repeat (8) @(posedge clk_sys);
		arst_n <= 1'b1;

		// Idle board with no game loaded
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_ports({8'hFF, 8'hFF, {2'b00, vcount[7:2]}, 8'hC0});
		check_value("dip2", dip2, 8'h00);
		count_pulses(cpu_n, pix_n);
		check_value("cpu_ena pulses", cpu_n, 4);
		check_value("pix_ena pulses", pix_n, 12);

		build_table();
		foreach (table_rows[i]) begin
			apply_row(table_rows[i]);
		end

		// DIP bank writes where the last address is out of range
		write_config(GAME_ID_INDEX, 25'd0, SPACE_PANIC);
		for (int a = 0; a <= DIP_BANKS; a++) begin
			r    = $urandom;
			data = (a < DIP_BANKS) ? r[7:0] : ~dip_model[0];
			write_config(DIP_INDEX, 25'(a), data);
			if (a < DIP_BANKS)
				dip_model[a] = data;
			repeat (2) @(posedge clk_sys);
			@(negedge clk_sys);
			check_value("ports.dip", ports.dip, dip_model[0]);
			check_value("dip2", dip2, dip_model[1]);
			check_value("flip", flip, dip_model[2][0]);
		end

		// CPU rate per game, then the loaded switches in that game's layout
		for (int g = 1; g <= 5; g++) begin
			write_config(GAME_ID_INDEX, 25'd0, 8'(g));
			@(posedge clk_sys);
			count_pulses(cpu_n, pix_n);
			fast = (g == 2) || (g == 4);
			check_value("cpu_ena pulses", cpu_n, fast ? 6 : 4);
			check_ports(expected_ports(game_id_t'(8'(g)), joy1, joy2, vblank, vcount,
				dip_model));
		end

		$display("test passed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk_sys);
		$display("timeout: tests still running after %0d clock cycles", LIMIT_CYCLES);
		stop_on_failure();
	end

endmodule

//--- flist.f
+incdir+.
arcade_cfg_pkg.sv
arcade_input_pkg.sv
ps2_key_decoder.sv
config_loader.sv
cpu_clock_enables.sv
input_port_mapper.sv
cosmic_inputs_top.sv
tb_cosmic_inputs.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cosmic_inputs -f flist.f -o tb_cosmic_inputs
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/tb_cosmic_inputs > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi

exit 0
